//--- verilog/keccak_pkg.sv
// keccak_pkg: shared widths, constants and bundles for the SHA3-512 Keccak datapath
`default_nettype none

package keccak_pkg;

    typedef logic [63:0]   lane_t;         // one keccak lane, also one message word
    typedef logic [1599:0] state_t;        // lane x+5y sits at bits 64*(x+5y) upward
    typedef logic [575:0]  block_t;        // rate block, lanes 0..8 map onto state lanes 0..8
    typedef logic [511:0]  digest_t;       // first digest byte sits in the top 8 bits
    typedef logic [4:0]    round_idx_t;    // round number 0..23
    typedef logic [3:0]    byte_cnt_t;     // valid bytes in a last word, 0..8

    localparam int ROUNDS       = 24;      // keccak-f[1600] round count
    localparam int RATE_LANES   = 9;       // 576-bit rate for sha3-512
    localparam int DIGEST_LANES = 8;       // 512 output bits

    localparam logic [7:0] PAD_DOMAIN = 8'h06;  // sha-3 domain bits plus first pad bit
    localparam logic [7:0] PAD_FINAL  = 8'h80;  // closing pad bit in the last rate byte

    // one word from the host, byte k of the word in bits 8k+7..8k
    typedef struct packed {
        lane_t     data;
        logic      last;                   // final word of the message
        byte_cnt_t nbytes;                 // only meaningful when last is set
    } msg_word_t;

    // one padded block on its way to the permutation
    typedef struct packed {
        block_t data;
        logic   first;                     // zero the state before absorbing
        logic   last;                      // final padded block of the message
    } absorb_blk_t;

endpackage

`default_nettype wire

//--- verilog/keccak_round_const.sv
// keccak_round_const: iota round constant lookup for keccak-f[1600]
`timescale 1ns/1ps
`default_nettype none

module keccak_round_const (
    input  keccak_pkg::round_idx_t round,
    output keccak_pkg::lane_t      rc
);

    always_comb begin
        case (round)                                   // standard iota constants, lane bit z at bit z
            5'd0:    rc = 64'h0000_0000_0000_0001;
            5'd1:    rc = 64'h0000_0000_0000_8082;
            5'd2:    rc = 64'h8000_0000_0000_808a;
            5'd3:    rc = 64'h8000_0000_8000_8000;
            5'd4:    rc = 64'h0000_0000_0000_808b;
            5'd5:    rc = 64'h0000_0000_8000_0001;
            5'd6:    rc = 64'h8000_0000_8000_8081;
            5'd7:    rc = 64'h8000_0000_0000_8009;
            5'd8:    rc = 64'h0000_0000_0000_008a;
            5'd9:    rc = 64'h0000_0000_0000_0088;
            5'd10:   rc = 64'h0000_0000_8000_8009;
            5'd11:   rc = 64'h0000_0000_8000_000a;
            5'd12:   rc = 64'h0000_0000_8000_808b;
            5'd13:   rc = 64'h8000_0000_0000_008b;
            5'd14:   rc = 64'h8000_0000_0000_8089;
            5'd15:   rc = 64'h8000_0000_0000_8003;
            5'd16:   rc = 64'h8000_0000_0000_8002;
            5'd17:   rc = 64'h8000_0000_0000_0080;
            5'd18:   rc = 64'h0000_0000_0000_800a;
            5'd19:   rc = 64'h8000_0000_8000_000a;
            5'd20:   rc = 64'h8000_0000_8000_8081;
            5'd21:   rc = 64'h8000_0000_0000_8080;
            5'd22:   rc = 64'h0000_0000_8000_0001;
            5'd23:   rc = 64'h8000_0000_8000_8008;
            default: rc = 64'h0;                       // indices 24..31 never used
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/keccak_round.sv
// keccak_round: one combinational keccak-f[1600] round, theta rho pi chi iota
`timescale 1ns/1ps
`default_nettype none

module keccak_round (
    input  keccak_pkg::state_t state_in,
    input  keccak_pkg::lane_t  rc,
    output keccak_pkg::state_t state_out
);
    import keccak_pkg::*;

    // rho rotation offsets, indexed by x+5y
    localparam int RHO_OFS [25] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    // rotate a lane left, a shift of 64 yields zero so n = 0 is safe
    function automatic lane_t rotl(input lane_t v, input int n);
        return (v << n) | (v >> (64 - n));
    endfunction

    lane_t a [25];                                    // input lanes
    lane_t c [5];                                     // column parities
    lane_t d [5];                                     // theta correction per column
    lane_t b [25];                                    // lanes after theta, rho and pi
    lane_t e [25];                                    // lanes after chi and iota

    always_comb begin
        for (int i = 0; i < 25; i++) begin
            a[i] = state_in[64*i +: 64];
        end
        for (int x = 0; x < 5; x++) begin
            c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
        end
        for (int x = 0; x < 5; x++) begin
            d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);  // left neighbour plus rotated right one
        end
        // theta xor, then rotate by rho and move lane (x,y) to (y, 2x+3y)
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                b[y + 5*((2*x + 3*y) % 5)] = rotl(a[x + 5*y] ^ d[x], RHO_OFS[x + 5*y]);
            end
        end
        // chi works along each row
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                e[x + 5*y] = b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
            end
        end
        e[0] = e[0] ^ rc;                             // iota only touches lane (0,0)
        for (int i = 0; i < 25; i++) begin
            state_out[64*i +: 64] = e[i];
        end
    end

endmodule

`default_nettype wire

//--- verilog/keccak_padder.sv
// keccak_padder: gathers host words into 576-bit rate blocks and applies sha-3 padding
`timescale 1ns/1ps
`default_nettype none

module keccak_padder (
    input  wire                     clk,
    input  wire                     reset,
    input  keccak_pkg::msg_word_t   msg,
    input  wire                     msg_valid,
    output logic                    msg_ack,
    output keccak_pkg::absorb_blk_t blk,
    output logic                    blk_ready,
    input  wire                     blk_ack
);
    import keccak_pkg::*;

    typedef enum logic [1:0] {
        COLLECT,                            // taking words from the host
        HOLD,                               // block offered to the permutation
        PAD_ONLY                            // building the extra padding block
    } pad_state_e;

    pad_state_e state;
    logic [3:0] lane_idx;                   // next lane to fill, 0..8
    block_t     blk_data;                   // block under construction or on offer
    block_t     next_blk;                   // block after writing the current word
    lane_t      word_pad;                   // current word with tail bytes masked and padded
    logic       blk_first;                  // block being built starts a message
    logic       blk_last;                   // block on offer closes the message
    logic       pad_pending;                // a padding-only block must follow
    logic       word_full;                  // last word carries all 8 bytes
    logic       overflow;                   // no room left for padding in this block

    assign msg_ack   = (state == COLLECT) && msg_valid;  // take the word in the same cycle
    assign blk_ready = (state == HOLD);

    assign blk.data  = blk_data;
    assign blk.first = blk_first;
    assign blk.last  = blk_last;

    assign word_full = (msg.nbytes == byte_cnt_t'(8));
    assign overflow  = msg.last && word_full && (lane_idx == 4'(RATE_LANES - 1));

    always_comb begin
        word_pad = msg.data;
        if (msg.last) begin                                  // mask the tail, place 0x06
            for (int k = 0; k < 8; k++) begin
                if (k == int'(msg.nbytes)) begin
                    word_pad[8*k +: 8] = PAD_DOMAIN;
                end else if (k > int'(msg.nbytes)) begin
                    word_pad[8*k +: 8] = 8'h00;
                end
            end
        end
        next_blk = blk_data;
        for (int i = 0; i < RATE_LANES; i++) begin
            if (i == int'(lane_idx)) begin
                next_blk[64*i +: 64] = word_pad;
            end else if (i > int'(lane_idx)) begin            // lanes not yet written are zero
                if (msg.last && word_full && (i == int'(lane_idx) + 1)) begin
                    next_blk[64*i +: 64] = {56'b0, PAD_DOMAIN}; // 0x06 spills to next lane
                end else begin
                    next_blk[64*i +: 64] = '0;
                end
            end
        end
        if (msg.last && !overflow) begin
            next_blk[575 -: 8] = next_blk[575 -: 8] | PAD_FINAL;  // may merge into 0x86
        end
    end

    // block payload, written lane by lane, no reset needed
    always_ff @(posedge clk) begin
        if (msg_ack) begin
            blk_data <= next_blk;
        end else if (state == PAD_ONLY) begin
            blk_data <= {PAD_FINAL, 560'b0, PAD_DOMAIN};   // whole block is padding
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= COLLECT;
            lane_idx    <= '0;
            blk_first   <= 1'b1;                            // first block after reset starts a message
            blk_last    <= 1'b0;
            pad_pending <= 1'b0;
        end else begin
            case (state)
                COLLECT: begin
                    if (msg_ack) begin
                        if (msg.last || (lane_idx == 4'(RATE_LANES - 1))) begin
                            state       <= HOLD;            // block is complete
                            lane_idx    <= '0;
                            blk_last    <= msg.last && !overflow;
                            pad_pending <= overflow;
                        end else begin
                            lane_idx <= lane_idx + 4'd1;
                        end
                    end
                end
                HOLD: begin
                    if (blk_ack) begin
                        blk_first <= blk_last;              // after a last block a new message begins
                        state     <= pad_pending ? PAD_ONLY : COLLECT;
                    end
                end
                PAD_ONLY: begin
                    state       <= HOLD;
                    blk_last    <= 1'b1;
                    pad_pending <= 1'b0;
                end
                default: begin
                    state <= COLLECT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/keccak_permutation.sv
// keccak_permutation: absorbs a rate block and runs 24 keccak rounds, one per clock
`timescale 1ns/1ps
`default_nettype none

module keccak_permutation (
    input  wire                     clk,
    input  wire                     reset,
    input  keccak_pkg::absorb_blk_t blk,
    input  wire                     blk_ready,
    output logic                    blk_ack,
    output keccak_pkg::state_t      perm_state,
    output logic                    perm_done,
    output logic                    perm_last,
    output logic                    perm_start_first
);
    import keccak_pkg::*;

    round_idx_t rnd;                                  // round applied in the current busy cycle
    round_idx_t rc_idx;                               // round index fed to the constant table
    logic       busy;                                 // rounds 1..23 still to go
    logic       accept;                               // block taken this cycle
    state_t     round_in;
    state_t     round_out;
    lane_t      rc;

    assign accept           = blk_ready && !busy;     // only take a block while idle
    assign blk_ack          = accept;
    assign perm_start_first = accept && blk.first;
    assign rc_idx           = accept ? '0 : rnd;      // the accept cycle does round 0

    // a first block absorbs into zero, later blocks into the held state
    assign round_in = accept ? ((blk.first ? '0 : perm_state) ^ state_t'(blk.data))
                             : perm_state;

    keccak_round_const i_round_const (
        .round (rc_idx),
        .rc    (rc)
    );

    keccak_round i_round (
        .state_in  (round_in),
        .rc        (rc),
        .state_out (round_out)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            rnd        <= '0;
            busy       <= 1'b0;
            perm_done  <= 1'b0;
            perm_last  <= 1'b0;
            perm_state <= '0;
        end else begin
            if (accept) begin
                rnd       <= round_idx_t'(1);
                busy      <= 1'b1;
                perm_done <= 1'b0;                    // result is stale from now on
                perm_last <= blk.last;                // tag travels with the block
            end else if (busy) begin
                rnd <= rnd + round_idx_t'(1);
                if (rnd == round_idx_t'(ROUNDS - 1)) begin
                    busy      <= 1'b0;
                    perm_done <= 1'b1;                // round 23 written on this edge
                end
            end
            if (accept || busy) begin
                perm_state <= round_out;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/keccak_digest.sv
// keccak_digest: captures the final state and presents the sha3-512 digest in byte order
`timescale 1ns/1ps
`default_nettype none

module keccak_digest (
    input  wire                 clk,
    input  wire                 reset,
    input  keccak_pkg::state_t  perm_state,
    input  wire                 perm_done,
    input  wire                 perm_last,
    input  wire                 perm_start_first,
    output keccak_pkg::digest_t digest,
    output logic                digest_valid
);
    import keccak_pkg::*;

    logic    done_q;                                  // perm_done one cycle ago
    logic    rise_last;                               // final block just finished
    logic    clear_q;                                 // drop valid after a colliding start
    digest_t swapped;                                 // state bytes in digest order

    assign rise_last = perm_done && !done_q && perm_last;

    always_comb begin
        for (int j = 0; j < DIGEST_LANES * 8; j++) begin
            swapped[511 - 8*j -: 8] = perm_state[8*j +: 8];  // state byte 0 lands on top
        end
    end

    always_ff @(posedge clk) begin
        if (rise_last) begin
            digest <= swapped;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done_q       <= 1'b0;
            clear_q      <= 1'b0;
            digest_valid <= 1'b0;
        end else begin
            done_q  <= perm_done;
            clear_q <= rise_last && perm_start_first;  // new message accepted in the same cycle
            if (rise_last) begin
                digest_valid <= 1'b1;
            end else if (perm_start_first || clear_q) begin
                digest_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/sha3_512_top.sv
// sha3_512_top: sha3-512 hasher, padder feeding the permutation feeding the digest stage
`timescale 1ns/1ps
`default_nettype none

module sha3_512_top (
    input  wire                   clk,
    input  wire                   reset,
    input  keccak_pkg::msg_word_t msg,
    input  wire                   msg_valid,
    output logic                  msg_ack,
    output keccak_pkg::digest_t   digest,
    output logic                  digest_valid
);
    import keccak_pkg::*;

    absorb_blk_t blk;                                 // padded block from decode to execute
    logic        blk_ready;
    logic        blk_ack;
    state_t      perm_state;                          // execute result to the result stage
    logic        perm_done;
    logic        perm_last;
    logic        perm_start_first;

    keccak_padder i_padder (
        .clk       (clk),
        .reset     (reset),
        .msg       (msg),
        .msg_valid (msg_valid),
        .msg_ack   (msg_ack),
        .blk       (blk),
        .blk_ready (blk_ready),
        .blk_ack   (blk_ack)
    );

    keccak_permutation i_permutation (
        .clk              (clk),
        .reset            (reset),
        .blk              (blk),
        .blk_ready        (blk_ready),
        .blk_ack          (blk_ack),
        .perm_state       (perm_state),
        .perm_done        (perm_done),
        .perm_last        (perm_last),
        .perm_start_first (perm_start_first)
    );

    keccak_digest i_digest (
        .clk              (clk),
        .reset            (reset),
        .perm_state       (perm_state),
        .perm_done        (perm_done),
        .perm_last        (perm_last),
        .perm_start_first (perm_start_first),
        .digest           (digest),
        .digest_valid     (digest_valid)
    );

endmodule

`default_nettype wire

//--- verif/sha3_512_tb.sv
// sha3_512_tb: testbench for the sha3-512 hasher with known answers, multi-block and handshake checks
`timescale 1ns/1ps
`default_nettype none

module sha3_512_tb;
    import keccak_pkg::*;

    // about 6 tests x 4 blocks x (9 words + 25 cycles), with room for random gaps
    localparam int TIMEOUT_CYCLES = 5000;

    localparam digest_t EMPTY_DIGEST = {
        256'ha69f73cca23a9ac5c8b567dc185a756e97c982164fe25859e0d1dcc1475c80a6,
        256'h15b2123af1f5f94c11e3e9402c3ac558f500199d95b6d3e301758586281dcd26
    };
    localparam digest_t ABC_DIGEST = {
        256'hb751850b1a57168a5693cd924b6b096e08f621827444f70d884f5d0240d2712e,
        256'h10e116e9192af3c91a7ec57647e3934057340b4cf408d5a56592f8274eec53f0
    };

    logic       clk = 1'b0;
    logic       reset;
    msg_word_t  msg;
    logic       msg_valid;
    logic       msg_ack;
    digest_t    digest;
    logic       digest_valid;

    integer     seed;                                 // state of the $random stream
    int         cycles = 0;                           // watchdog count of rising edges
    int         acks = 0;                             // words taken by the DUT so far
    int         errors = 0;                           // failed checks over the whole run
    int         errors_at_start = 0;                  // error count when the current test began
    int         tests_ok = 0;
    int         tests_bad = 0;
    logic [7:0] bytes_q [$];                          // message under test, first byte at index 0
    digest_t    d_first;
    digest_t    d_second;
    int         acks_before;
    int         low_cycles;                           // cycles with digest_valid low between messages
    int         wait_cnt;

    sha3_512_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .msg          (msg),
        .msg_valid    (msg_valid),
        .msg_ack      (msg_ack),
        .digest       (digest),
        .digest_valid (digest_valid)
    );

    always #2 clk = ~clk;                             // 4 ns period

    always @(posedge clk) begin
        if (msg_ack) begin
            acks <= acks + 1;                         // one word taken on this edge
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // holds one word on the bus until the DUT acks it, starting and ending on a falling edge
    task automatic send_word(input msg_word_t w, input int idle);
        logic taken;
        msg_valid = 1'b0;
        repeat (idle) @(negedge clk);                 // idle cycles between words
        msg       = w;
        msg_valid = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            #1;                                       // ack is settled in the low half of the clock
            taken = msg_ack;
            @(negedge clk);
        end
        msg_valid = 1'b0;
    endtask

    // splits a byte queue into 64-bit words, byte k of a word in bits 8k+7..8k
    task automatic send_message(input logic [7:0] data_q [$], input logic gaps);
        int        nwords;
        int        idle;
        msg_word_t w;
        nwords = (data_q.size() == 0) ? 1 : (data_q.size() + 7) / 8;  // empty message is one word
        for (int i = 0; i < nwords; i++) begin
            w = '0;
            for (int k = 0; k < 8; k++) begin
                if (8*i + k < data_q.size()) begin
                    w.data[8*k +: 8] = data_q[8*i + k];
                end
            end
            w.last   = (i == nwords - 1);
            w.nbytes = w.last ? byte_cnt_t'(data_q.size() - 8*i) : '0;
            idle     = gaps ? int'($unsigned($random(seed)) % 4) : 0;
            send_word(w, idle);
        end
    endtask

    // the previous digest drops once the new message is accepted, then the new one rises
    task automatic wait_new_digest(output digest_t d);
        while (digest_valid) begin
            @(negedge clk);
        end
        while (!digest_valid) begin
            @(negedge clk);
        end
        d = digest;
    endtask

    task automatic check_digest(input digest_t got, input digest_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED: digest got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("%-36s ok", name);
            tests_ok++;
        end else begin
            $display("%-36s FAILED with %0d errors", name, errors - errors_at_start);
            tests_bad++;
        end
        errors_at_start = errors;
    endtask

    initial begin
        seed      = 32'hbf9e_8592;
        reset     = 1'b1;
        msg       = '0;
        msg_valid = 1'b0;

        repeat (8) begin                              // reset held for 8 rising edges
            @(negedge clk);
            assert (!digest_valid && !msg_ack) else begin
                $display("digest_valid or msg_ack is high while reset is asserted");
                errors++;
            end
        end
        reset = 1'b0;
        repeat (2) begin
            @(negedge clk);
            assert (!digest_valid && !msg_ack) else begin
                $display("digest_valid or msg_ack is high right after reset with no input");
                errors++;
            end
        end
        end_test("reset state");

        bytes_q.delete();
        send_message(bytes_q, 1'b0);
        wait_new_digest(d_first);
        check_digest(d_first, EMPTY_DIGEST);
        end_test("empty message known answer");

        bytes_q = '{8'h61, 8'h62, 8'h63};             // "abc"
        send_message(bytes_q, 1'b1);
        wait_new_digest(d_first);
        check_digest(d_first, ABC_DIGEST);
        end_test("abc known answer");

        bytes_q.delete();
        for (int i = 0; i < 200; i++) begin
            bytes_q.push_back(8'($random(seed)));
        end
        acks_before = acks;
        send_message(bytes_q, 1'b0);
        wait_new_digest(d_first);
        check_count("msg_ack count", acks - acks_before, 25);  // 200 bytes in 25 words
        acks_before = acks;
        send_message(bytes_q, 1'b1);
        wait_new_digest(d_second);
        check_count("msg_ack count", acks - acks_before, 25);
        check_digest(d_second, d_first);
        end_test("200 bytes with and without gaps");

        bytes_q.delete();
        for (int i = 0; i < 72; i++) begin
            bytes_q.push_back(8'(i * 37 + 11));       // 9 full words leave no room for padding
        end
        send_message(bytes_q, 1'b0);
        wait_new_digest(d_first);
        send_message(bytes_q, 1'b1);
        wait_new_digest(d_second);
        check_digest(d_second, d_first);
        bytes_q[40] = bytes_q[40] ^ 8'h01;
        send_message(bytes_q, 1'b0);
        wait_new_digest(d_second);
        assert (d_second !== d_first) else begin
            $display("changing one byte of the 72 byte message left the digest unchanged");
            errors++;
        end
        end_test("72 bytes with padding-only block");

        bytes_q = '{8'h61, 8'h62, 8'h63};
        send_message(bytes_q, 1'b0);
        wait_new_digest(d_first);
        check_digest(d_first, ABC_DIGEST);
        bytes_q.delete();
        send_message(bytes_q, 1'b1);                  // returns in the cycle the block is accepted
        wait_cnt = 0;
        while (digest_valid && wait_cnt < 4) begin
            @(negedge clk);
            wait_cnt++;
        end
        assert (!digest_valid) else begin
            $display("digest_valid did not fall after the next message started");
            errors++;
        end
        low_cycles = 0;
        while (!digest_valid) begin
            low_cycles++;
            @(negedge clk);
        end
        check_count("digest_valid low cycles", low_cycles, 24);  // done at A+24, valid at A+25
        check_digest(digest, EMPTY_DIGEST);
        repeat (10) begin                             // no new message, digest must hold
            @(negedge clk);
            assert (digest_valid && digest === EMPTY_DIGEST) else begin
                $display("digest changed or digest_valid dropped while no message was sent");
                errors++;
            end
        end
        end_test("digest_valid across messages");

        $display("%0d tests ok, %0d tests with errors, %0d failed checks",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
verilog/keccak_pkg.sv
verilog/keccak_round_const.sv
verilog/keccak_round.sv
verilog/keccak_padder.sv
verilog/keccak_permutation.sv
verilog/keccak_digest.sv
verilog/sha3_512_top.sv
verif/sha3_512_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the sha3-512 testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module sha3_512_tb -Mdir "$OBJ" -o sha3_512_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/sha3_512_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
